//--- tl_pkg.sv
package tl_pkg;

    // a single-beat bus carries one address and one data word per request.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // request opcodes follow the usual TileLink channel A encoding.
    typedef enum logic [2:0] {
        PutFullData    = 3'd0,
        PutPartialData = 3'd1,
        Get            = 3'd4
    } tl_a_op_e;

    // response opcodes follow the channel D encoding.
    typedef enum logic [2:0] {
        AccessAck     = 3'd0,
        AccessAckData = 3'd1
    } tl_d_op_e;

endpackage

//--- uart_pkg.sv
package uart_pkg;

    localparam logic [31:0] UART_BASE = 32'h2000_0000;
    localparam logic [31:0] UART_MASK = 32'h0000_000F;

    localparam logic [31:0] REG_CTRL   = 32'h0;
    localparam logic [31:0] REG_STATUS = 32'h4;
    localparam logic [31:0] REG_RDATA  = 32'h8;
    localparam logic [31:0] REG_WDATA  = 32'hC;

    // control word layout.
    localparam int CTRL_TX_EN    = 0;
    localparam int CTRL_RX_EN    = 1;
    localparam int CTRL_BAUD_LSB = 16;
    localparam int CTRL_BAUD_MSB = 31;
    localparam int BAUD_W        = CTRL_BAUD_MSB - CTRL_BAUD_LSB + 1;

    // status word layout.
    localparam int TX_FULL  = 0;
    localparam int TX_EMPTY = 1;
    localparam int RX_FULL  = 2;
    localparam int RX_EMPTY = 3;

    localparam int FIFO_DEPTH = 32;
    localparam int BYTE_W     = 8;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        WAIT_SPACE
    } reg_state_e;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 32
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  wr_en_i,
    input  logic                  rd_en_i,
    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W:0]        count_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the FIFO falls through, so the head word is always on the output.
    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       rx_i,
    input  logic [uart_pkg::BAUD_W-1:0] baud_div_i,
    output logic [uart_pkg::BYTE_W-1:0] byte_o,
    output logic                       byte_valid_o
);

    import uart_pkg::*;

    localparam int IDX_W = $clog2(BYTE_W);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e         state_q;
    logic              rx_meta_q;
    logic              rx_sync_q;
    logic              rx_prev_q;
    logic [BAUD_W-1:0] cnt_q;
    logic [IDX_W-1:0]  bit_idx_q;
    logic [BYTE_W-1:0] shift_q;
    logic              valid_q;
    logic              bit_done;

    assign bit_done = (cnt_q == baud_div_i - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            // the idle line is high, so the synchronizer starts there.
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
            valid_q   <= 1'b0;
            cnt_q     <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (rx_prev_q && !rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // a glitch shorter than half a bit is not a start bit.
                    if (cnt_q == {1'b0, baud_div_i[BAUD_W-1:1]}) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == IDX_W'(BYTE_W - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        valid_q <= rx_sync_q;
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first and shift in from the top.
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_done) begin
            shift_q <= {rx_sync_q, shift_q[BYTE_W-1:1]};
        end
    end

    assign byte_o       = shift_q;
    assign byte_valid_o = valid_q;

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       tx_en_i,
    input  logic                       data_valid_i,
    input  logic [uart_pkg::BYTE_W-1:0] data_i,
    input  logic [uart_pkg::BAUD_W-1:0] baud_div_i,
    output logic                       consume_o,
    output logic                       tx_o
);

    import uart_pkg::*;

    localparam int IDX_W = $clog2(BYTE_W);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e         state_q;
    logic [BAUD_W-1:0] cnt_q;
    logic [IDX_W-1:0]  bit_idx_q;
    logic [BYTE_W-1:0] shift_q;
    logic              tx_q;
    logic              bit_done;

    // the enable only gates the start of a frame.
    assign consume_o = (state_q == TX_IDLE) && tx_en_i && data_valid_i;
    assign bit_done  = (cnt_q == baud_div_i - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    if (consume_o) begin
                        tx_q    <= 1'b0;
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        tx_q      <= shift_q[0];
                        bit_idx_q <= '0;
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == IDX_W'(BYTE_W - 1)) begin
                            tx_q    <= 1'b1;
                            state_q <= TX_STOP;
                        end else begin
                            tx_q <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (consume_o) begin
            shift_q <= data_i;
        end else if (state_q == TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_o = tx_q;

endmodule

//--- uart_reg_if.sv
`timescale 1ns/1ps

module uart_reg_if (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic [tl_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [tl_pkg::DATA_W-1:0]   req_data_i,
    input  tl_pkg::tl_a_op_e            req_opcode_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    output logic [tl_pkg::DATA_W-1:0]   rsp_data_o,
    output tl_pkg::tl_d_op_e            rsp_opcode_o,
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    input  logic                        tx_full_i,
    input  logic                        tx_empty_i,
    input  logic                        rx_full_i,
    input  logic                        rx_empty_i,
    input  logic [uart_pkg::BYTE_W-1:0] rx_fifo_data_i,
    input  logic [uart_pkg::BYTE_W-1:0] rx_byte_i,
    input  logic                        rx_byte_valid_i,
    output logic                        tx_wr_en_o,
    output logic [uart_pkg::BYTE_W-1:0] tx_wr_data_o,
    output logic                        rx_wr_en_o,
    output logic [uart_pkg::BYTE_W-1:0] rx_wr_data_o,
    output logic                        rx_rd_en_o,
    output logic                        tx_en_o,
    output logic                        rx_en_o,
    output logic [uart_pkg::BAUD_W-1:0] baud_div_o
);

    import tl_pkg::*;
    import uart_pkg::*;

    reg_state_e        state_q;
    reg_state_e        state_d;
    logic [DATA_W-1:0] ctrl_q;
    logic [DATA_W-1:0] ctrl_d;
    logic              rsp_valid_q;
    logic              rsp_valid_d;
    logic [DATA_W-1:0] rsp_data_q;
    logic [DATA_W-1:0] rsp_data_d;
    tl_d_op_e          rsp_opcode_q;
    tl_d_op_e          rsp_opcode_d;
    logic [BYTE_W-1:0] ovf_q;
    logic [BYTE_W-1:0] ovf_d;
    logic [DATA_W-1:0] status_w;
    logic [ADDR_W-1:0] offset;
    logic              addr_hit;
    logic              is_write;
    logic              req_fire;

    assign addr_hit = (req_addr_i & ~UART_MASK) == UART_BASE;
    assign offset   = req_addr_i & UART_MASK;
    assign is_write = (req_opcode_i == PutFullData) || (req_opcode_i == PutPartialData);

    // a new request waits until the previous response is gone or leaving.
    assign req_ready_o = (state_q == IDLE) && (!rsp_valid_q || rsp_ready_i);
    assign req_fire    = req_valid_i && req_ready_o;

    always_comb begin
        status_w           = '0;
        status_w[TX_FULL]  = tx_full_i;
        status_w[TX_EMPTY] = tx_empty_i;
        status_w[RX_FULL]  = rx_full_i;
        status_w[RX_EMPTY] = rx_empty_i;
    end

    always_comb begin
        state_d      = state_q;
        ctrl_d       = ctrl_q;
        rsp_valid_d  = rsp_valid_q && !rsp_ready_i;
        rsp_data_d   = rsp_data_q;
        rsp_opcode_d = rsp_opcode_q;
        ovf_d        = ovf_q;
        tx_wr_en_o   = 1'b0;
        tx_wr_data_o = req_data_i[BYTE_W-1:0];
        rx_rd_en_o   = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_fire) begin
                    // unmapped or misdirected accesses get a plain ack or zero data.
                    rsp_valid_d  = 1'b1;
                    rsp_data_d   = '0;
                    rsp_opcode_d = is_write ? AccessAck : AccessAckData;
                    if (addr_hit && offset == REG_CTRL) begin
                        if (is_write) begin
                            ctrl_d = req_data_i;
                        end else begin
                            rsp_data_d = ctrl_q;
                        end
                    end else if (addr_hit && offset == REG_STATUS && !is_write) begin
                        rsp_data_d = status_w;
                    end else if (addr_hit && offset == REG_RDATA && !is_write) begin
                        if (rx_empty_i) begin
                            rsp_valid_d = 1'b0;
                            state_d     = WAIT_DATA;
                        end else begin
                            rsp_data_d = {{(DATA_W - BYTE_W){1'b0}}, rx_fifo_data_i};
                            rx_rd_en_o = 1'b1;
                        end
                    end else if (addr_hit && offset == REG_WDATA && is_write) begin
                        // a full FIFO still acks now, the byte waits in the buffer.
                        if (tx_full_i) begin
                            ovf_d   = req_data_i[BYTE_W-1:0];
                            state_d = WAIT_SPACE;
                        end else begin
                            tx_wr_en_o = 1'b1;
                        end
                    end
                end
            end
            WAIT_DATA: begin
                if (!rx_empty_i) begin
                    rsp_valid_d  = 1'b1;
                    rsp_data_d   = {{(DATA_W - BYTE_W){1'b0}}, rx_fifo_data_i};
                    rsp_opcode_d = AccessAckData;
                    rx_rd_en_o   = 1'b1;
                    state_d      = IDLE;
                end
            end
            WAIT_SPACE: begin
                if (!tx_full_i) begin
                    tx_wr_en_o   = 1'b1;
                    tx_wr_data_o = ovf_q;
                    state_d      = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            ctrl_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            ctrl_q      <= ctrl_d;
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_data_q   <= rsp_data_d;
        rsp_opcode_q <= rsp_opcode_d;
        ovf_q        <= ovf_d;
    end

    // received bytes are dropped while receive is off or the FIFO is full.
    assign rx_wr_en_o   = rx_byte_valid_i && ctrl_q[CTRL_RX_EN] && !rx_full_i;
    assign rx_wr_data_o = rx_byte_i;

    assign rsp_data_o   = rsp_data_q;
    assign rsp_opcode_o = rsp_opcode_q;
    assign rsp_valid_o  = rsp_valid_q;
    assign tx_en_o      = ctrl_q[CTRL_TX_EN];
    assign rx_en_o      = ctrl_q[CTRL_RX_EN];
    assign baud_div_o   = ctrl_q[CTRL_BAUD_MSB:CTRL_BAUD_LSB];

endmodule

//--- uart_periph.sv
`timescale 1ns/1ps

module uart_periph (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic [tl_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [tl_pkg::DATA_W-1:0] req_data_i,
    input  tl_pkg::tl_a_op_e          req_opcode_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    output logic [tl_pkg::DATA_W-1:0] rsp_data_o,
    output tl_pkg::tl_d_op_e          rsp_opcode_o,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    input  logic                      rx_i,
    output logic                      tx_o
);

    import uart_pkg::*;

    logic              tx_wr_en;
    logic [BYTE_W-1:0] tx_wr_data;
    logic [BYTE_W-1:0] tx_head;
    logic              tx_full;
    logic              tx_empty;
    logic              tx_consume;
    logic              rx_wr_en;
    logic [BYTE_W-1:0] rx_wr_data;
    logic              rx_rd_en;
    logic [BYTE_W-1:0] rx_head;
    logic              rx_full;
    logic              rx_empty;
    logic [BYTE_W-1:0] rx_byte;
    logic              rx_byte_valid;
    logic              tx_en;
    logic [BAUD_W-1:0] baud_div;

    uart_reg_if i_reg_if (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_addr_i      (req_addr_i),
        .req_data_i      (req_data_i),
        .req_opcode_i    (req_opcode_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_opcode_o    (rsp_opcode_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .tx_full_i       (tx_full),
        .tx_empty_i      (tx_empty),
        .rx_full_i       (rx_full),
        .rx_empty_i      (rx_empty),
        .rx_fifo_data_i  (rx_head),
        .rx_byte_i       (rx_byte),
        .rx_byte_valid_i (rx_byte_valid),
        .tx_wr_en_o      (tx_wr_en),
        .tx_wr_data_o    (tx_wr_data),
        .rx_wr_en_o      (rx_wr_en),
        .rx_wr_data_o    (rx_wr_data),
        .rx_rd_en_o      (rx_rd_en),
        .tx_en_o         (tx_en),
        .rx_en_o         (),
        .baud_div_o      (baud_div)
    );

    sync_fifo #(
        .DATA_WIDTH (BYTE_W),
        .DEPTH      (FIFO_DEPTH)
    ) i_tx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (tx_wr_data),
        .wr_en_i (tx_wr_en),
        .rd_en_i (tx_consume),
        .data_o  (tx_head),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    sync_fifo #(
        .DATA_WIDTH (BYTE_W),
        .DEPTH      (FIFO_DEPTH)
    ) i_rx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (rx_wr_data),
        .wr_en_i (rx_wr_en),
        .rd_en_i (rx_rd_en),
        .data_o  (rx_head),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

    // the receiver runs even when disabled and the register block drops its bytes.
    uart_rx i_rx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rx_i         (rx_i),
        .baud_div_i   (baud_div),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    uart_tx i_tx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .tx_en_i      (tx_en),
        .data_valid_i (!tx_empty),
        .data_i       (tx_head),
        .baud_div_i   (baud_div),
        .consume_o    (tx_consume),
        .tx_o         (tx_o)
    );

endmodule

//--- uart_periph_assert.sv
`timescale 1ns/1ps

module uart_periph_assert (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      req_ready_i,
    input  logic                      rsp_valid_i,
    input  logic                      rsp_ready_i,
    input  logic [tl_pkg::DATA_W-1:0] rsp_data_i,
    input  tl_pkg::tl_d_op_e          rsp_opcode_i,
    input  uart_pkg::reg_state_e      state_i,
    input  logic                      tx_en_i,
    input  logic                      tx_i
);

    import uart_pkg::*;

    int error_count = 0;

    // a pending response may not change or vanish before the handshake.
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_i && !rsp_ready_i |=>
            rsp_valid_i && $stable(rsp_data_i) && $stable(rsp_opcode_i))
    else begin
        $error("response changed before it was accepted");
        error_count++;
    end

    // a read that waits for data has no response pending.
    busy_not_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_i != IDLE |-> !req_ready_i && (state_i == WAIT_SPACE || !rsp_valid_i))
    else begin
        $error("request channel ready or response pending while the register block is busy");
        error_count++;
    end

    tx_idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !tx_en_i |-> tx_i)
    else begin
        $error("serial output low while transmit is disabled");
        error_count++;
    end

endmodule

bind uart_periph uart_periph_assert i_assert (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_ready_i  (req_ready_o),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_data_i   (rsp_data_o),
    .rsp_opcode_i (rsp_opcode_o),
    .state_i      (i_reg_if.state_q),
    .tx_en_i      (tx_en),
    .tx_i         (tx_o)
);

//--- tb_uart_periph.sv
`timescale 1ns/1ps

module tb_uart_periph;

    import tl_pkg::*;
    import uart_pkg::*;

    localparam int CLK_NS      = 10;
    localparam int BIT_CYCLES  = 8;
    localparam int FRAME_NS    = 10 * BIT_CYCLES * CLK_NS;
    localparam int NUM_FRAMES  = 45;
    localparam int NUM_OPS     = 110;
    // every bus operation gets room for response stalls and overflow waits.
    localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_NS + NUM_OPS * 40 * CLK_NS + 20 * CLK_NS;

    typedef struct packed {
        tl_a_op_e    op;
        logic [31:0] addr;
        logic [31:0] data;
    } req_t;

    typedef struct packed {
        tl_d_op_e    op;
        logic [31:0] data;
    } rsp_t;

    logic        clk_i;
    logic        rstn_i;
    logic [31:0] req_addr_i;
    logic [31:0] req_data_i;
    tl_a_op_e    req_opcode_i;
    logic        req_valid_i;
    logic        req_ready_o;
    logic [31:0] rsp_data_o;
    tl_d_op_e    rsp_opcode_o;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    logic        rx_i;
    logic        tx_o;

    // model of the peripheral as seen from the bus.
    logic [31:0] ctrl_model;
    int          tx_level;
    logic [7:0]  rx_model[$];
    logic [7:0]  tx_expected[$];
    req_t        pending[$];

    logic [31:0] rng;
    int          stall_max;
    int          errors;
    int          checks;
    int          requests;
    int          responses;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;

    uart_periph i_dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_addr_i   (req_addr_i),
        .req_data_i   (req_data_i),
        .req_opcode_i (req_opcode_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_data_o   (rsp_data_o),
        .rsp_opcode_o (rsp_opcode_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rx_i         (rx_i),
        .tx_o         (tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // the expected response comes from the register map and the model.
    function automatic rsp_t expect_response(input req_t r);
        rsp_t        e;
        logic [31:0] off;
        logic        hit;
        logic        wr;
        hit    = (r.addr & ~UART_MASK) == UART_BASE;
        off    = r.addr & UART_MASK;
        wr     = (r.op != Get);
        e.op   = wr ? AccessAck : AccessAckData;
        e.data = '0;
        if (hit && off == REG_CTRL) begin
            if (wr) begin
                ctrl_model = r.data;
            end else begin
                e.data = ctrl_model;
            end
        end else if (hit && off == REG_STATUS && !wr) begin
            e.data[TX_FULL]  = (tx_level >= FIFO_DEPTH);
            e.data[TX_EMPTY] = (tx_level == 0);
            e.data[RX_FULL]  = (rx_model.size() >= FIFO_DEPTH);
            e.data[RX_EMPTY] = (rx_model.size() == 0);
        end else if (hit && off == REG_RDATA && !wr) begin
            if (rx_model.size() == 0) begin
                $display("receive data answered although no frame was expected");
                errors++;
            end else begin
                e.data[7:0] = rx_model.pop_front();
            end
        end else if (hit && off == REG_WDATA && wr) begin
            tx_level++;
            tx_expected.push_back(r.data[7:0]);
        end
        return e;
    endfunction

    task automatic bus_access(input tl_a_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
        req_t r;
        int   stall;
        @(posedge clk_i);
        #1;
        req_opcode_i = op;
        req_addr_i   = addr;
        req_data_i   = data;
        req_valid_i  = 1'b1;
        rsp_ready_i  = 1'b0;
        do @(posedge clk_i); while (!req_ready_o);
        r.op   = op;
        r.addr = addr;
        r.data = data;
        pending.push_back(r);
        requests++;
        #1;
        req_valid_i = 1'b0;
        stall       = next_random() % (stall_max + 1);
        repeat (stall) begin
            @(posedge clk_i);
            #1;
        end
        rsp_ready_i = 1'b1;
        do @(posedge clk_i); while (!rsp_valid_o);
        #1;
        rsp_ready_i = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        if (ctrl_model[CTRL_RX_EN]) begin
            rx_model.push_back(b);
        end
        @(posedge clk_i);
        for (int i = 0; i < 10; i++) begin
            #1 rx_i = frame[i];
            repeat (BIT_CYCLES) @(posedge clk_i);
        end
        repeat (BIT_CYCLES) @(posedge clk_i);
    endtask

    task automatic wait_tx_drain();
        while (tx_expected.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2 * BIT_CYCLES) @(posedge clk_i);
        tx_level = 0;
    endtask

    task automatic end_test(input string name);
        int errs;
        repeat (4) @(posedge clk_i);
        assert (pending.size() == 0) else begin
            $display("%s left %0d requests without a response", name, pending.size());
            errors++;
        end
        assert (responses == requests) else begin
            $display("%s issued %0d requests but saw %0d responses", name, requests, responses);
            errors++;
        end
        errs = errors - errors_at_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errs);
        end
        errors_at_start = errors;
        requests        = 0;
        responses       = 0;
    endtask

    always @(posedge clk_i) begin
        req_t r;
        rsp_t e;
        if (rstn_i && rsp_valid_o && rsp_ready_i) begin
            if (pending.size() == 0) begin
                $display("a response arrived with no request outstanding");
                errors++;
            end else begin
                r = pending.pop_front();
                e = expect_response(r);
                responses++;
                checks += 2;
                assert (rsp_opcode_o == e.op) else begin
                    $display("Fail rsp_opcode_o at %h expected %h got %h",
                             r.addr, e.op, rsp_opcode_o);
                    errors++;
                end
                assert (rsp_data_o == e.data) else begin
                    $display("Fail rsp_data_o at %h expected %h got %h",
                             r.addr, e.data, rsp_data_o);
                    errors++;
                end
            end
        end
    end

    // decodes tx_o at the fixed divisor by sampling each bit in its middle.
    initial begin
        logic [7:0] b;
        logic [7:0] exp;
        forever begin
            @(negedge tx_o);
            if (rstn_i) begin
                repeat (BIT_CYCLES / 2) @(posedge clk_i);
                checks++;
                assert (tx_o == 1'b0) else begin
                    $display("Fail tx_o start bit expected %h got %h", 1'b0, tx_o);
                    errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(posedge clk_i);
                    b[i] = tx_o;
                end
                repeat (BIT_CYCLES) @(posedge clk_i);
                assert (tx_o == 1'b1) else begin
                    $display("Fail tx_o stop bit expected %h got %h", 1'b1, tx_o);
                    errors++;
                end
                if (tx_expected.size() == 0) begin
                    $display("a frame appeared on tx_o that was never written");
                    errors++;
                end else begin
                    exp = tx_expected.pop_front();
                    checks++;
                    assert (b == exp) else begin
                        $display("Fail tx_o byte expected %h got %h", exp, b);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not complete within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          kind;
        rstn_i          = 1'b0;
        req_addr_i      = '0;
        req_data_i      = '0;
        req_opcode_i    = Get;
        req_valid_i     = 1'b0;
        rsp_ready_i     = 1'b0;
        rx_i            = 1'b1;
        ctrl_model      = '0;
        tx_level        = 0;
        rng             = 32'h9c3b_7d0d;
        stall_max       = 3;
        errors          = 0;
        checks          = 0;
        requests        = 0;
        responses       = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (10) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        bus_access(Get, UART_BASE + REG_STATUS, '0);
        bus_access(PutFullData, UART_BASE + REG_CTRL, 32'hA5A5_5A5C);
        bus_access(Get, UART_BASE + REG_CTRL, '0);
        bus_access(PutFullData, UART_BASE + 32'h6, 32'hDEAD_BEEF);
        bus_access(Get, UART_BASE + 32'h3, '0);
        bus_access(Get, 32'h3000_0000, '0);
        bus_access(PutFullData, UART_BASE + REG_STATUS, 32'hFFFF_FFFF);
        bus_access(Get, UART_BASE + REG_WDATA, '0);
        bus_access(Get, UART_BASE + REG_STATUS, '0);
        end_test("control_readback");

        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0001});
        bus_access(PutFullData, UART_BASE + REG_WDATA, 32'h55);
        bus_access(PutPartialData, UART_BASE + REG_WDATA, 32'h00);
        bus_access(PutFullData, UART_BASE + REG_WDATA, 32'hFF);
        bus_access(PutFullData, UART_BASE + REG_WDATA, 32'hC3);
        wait_tx_drain();
        end_test("transmit_path");

        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0002});
        send_frame(8'h3C);
        send_frame(8'h81);
        send_frame(8'h7E);
        repeat (3) bus_access(Get, UART_BASE + REG_RDATA, '0);
        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0000});
        send_frame(8'h11);
        send_frame(8'h22);
        bus_access(Get, UART_BASE + REG_STATUS, '0);
        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0002});
        send_frame(8'h5A);
        bus_access(Get, UART_BASE + REG_RDATA, '0);
        end_test("receive_path");

        // the read is issued first and stalls until the frame lands.
        fork
            bus_access(Get, UART_BASE + REG_RDATA, '0);
            begin
                repeat (30) @(posedge clk_i);
                send_frame(8'hA5);
            end
        join
        end_test("stall_on_empty");

        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0000});
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            rnd = next_random();
            bus_access(PutFullData, UART_BASE + REG_WDATA, {24'h0, rnd[7:0]});
        end
        bus_access(Get, UART_BASE + REG_STATUS, '0);
        bus_access(PutFullData, UART_BASE + REG_CTRL, {16'd8, 16'h0001});
        for (int i = 0; i < 2; i++) begin
            rnd = next_random();
            bus_access(PutFullData, UART_BASE + REG_WDATA, {24'h0, rnd[7:0]});
        end
        wait_tx_drain();
        end_test("full_transmit_fifo");

        stall_max = 12;
        for (int i = 0; i < 40; i++) begin
            rnd  = next_random();
            kind = rnd % 5;
            case (kind)
                0: bus_access(PutFullData, UART_BASE + REG_CTRL, rnd & ~32'h3);
                1: bus_access(Get, UART_BASE + REG_CTRL, '0);
                2: bus_access(Get, UART_BASE + REG_STATUS, '0);
                3: bus_access(Get, UART_BASE + 32'h1 + (rnd & 32'h2), '0);
                default: bus_access(PutPartialData, 32'h4000_0000 + (rnd & 32'hC), rnd);
            endcase
        end
        end_test("response_backpressure");

        errors = errors + i_dut.i_assert.error_count;
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- uart_periph.f
tl_pkg.sv
uart_pkg.sv
sync_fifo.sv
uart_rx.sv
uart_tx.sv
uart_reg_if.sv
uart_periph.sv
uart_periph_assert.sv
tb_uart_periph.sv

//--- Bender.yml
package:
  name: uart_periph

sources:
  - tl_pkg.sv
  - uart_pkg.sv
  - sync_fifo.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_reg_if.sv
  - uart_periph.sv
  - target: test
    files:
      - uart_periph_assert.sv
      - tb_uart_periph.sv
